/* sources.f */
fetchPkg.sv
fetchPcSelect.sv
imemBank.sv
fetchDecode.sv
decodeReg.sv
fetchStage.sv
tbFetchStage.sv

/* Makefile */
# Verilator build and run of the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tbFetchStage
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tbFetchStage.sv */
// fetchStage testbench with default parameters and 16 banks assumed for the random pc offsets
`timescale 1ns/1ps

module tbFetchStage;
    import fetchPkg::*;

    localparam int IMEM_BYTES   = 1024;
    localparam int ADDR_W       = $clog2(IMEM_BYTES);
    localparam int PROG_STEPS   = 12;
    localparam int RAND_FETCHES = 64;
    // reset, fill, program load, then the fetch tests
    localparam int TEST_CYCLES  = 10 + IMEM_BYTES + 64 + PROG_STEPS + 40 + RAND_FETCHES;
    localparam int CYCLE_LIMIT  = TEST_CYCLES + 200;

    localparam fetchBundleT BUBBLE_EXP = '{icode: ICODE_NOP, ifun: 4'h0, rA: 4'h0, rB: 4'h0,
                                           valC: '0, valP: '0, stat: STAT_AOK};
    localparam memFeedbackT NO_MEM     = '{icode: ICODE_NOP, cnd: 1'b0, valA: '0};
    localparam memFeedbackT JUMP_MISS  = '{icode: ICODE_JXX, cnd: 1'b0, valA: 64'h20};
    localparam memFeedbackT JUMP_TAKEN = '{icode: ICODE_JXX, cnd: 1'b1, valA: 64'h20};
    localparam wbFeedbackT  NO_WB      = '{icode: ICODE_NOP, valM: '0};
    localparam wbFeedbackT  RET_WB     = '{icode: ICODE_RET, valM: 64'h24};

    logic              clk;
    logic              rstN;
    logic [WORD_W-1:0] predPc;
    memFeedbackT       memFb;
    wbFeedbackT        wbFb;
    logic              stall;
    logic              bubble;
    logic              imemWrEn;
    logic [WORD_W-1:0] imemWrAddr;
    logic [7:0]        imemWrData;
    logic [WORD_W-1:0] fPredPc;
    fetchBundleT       dOut;

    // shadow of instruction memory updated at the edge the write lands
    logic [7:0]        shadow [IMEM_BYTES];
    fetchBundleT       expD;
    fetchBundleT       held;
    string             testName;
    string             expName;
    logic              armed;
    logic              memReady;
    logic [WORD_W-1:0] progAddr;
    logic [31:0]       randWord;
    integer            seed;
    int                errors;
    int                checks;
    int                cycles = 0;

    fetchStage #(.IMEM_BYTES(IMEM_BYTES)) UUT (.*);

    always #20 clk = ~clk;

    function automatic logic [7:0] shadowByte(input logic [WORD_W-1:0] addr);
        // nothing lives past the end of memory
        if (addr >= WORD_W'(IMEM_BYTES))
            return 8'h00;
        return shadow[addr[ADDR_W-1:0]];
    endfunction

    // redirect priority is not-taken jump then ret then prediction
    function automatic logic [WORD_W-1:0] refPc(input logic [WORD_W-1:0] pred,
                                                input memFeedbackT m, input wbFeedbackT w);
        if (m.icode == ICODE_JXX && !m.cnd)
            return m.valA;
        if (w.icode == ICODE_RET)
            return w.valM;
        return pred;
    endfunction

    function automatic fetchBundleT refFetch(input logic [WORD_W-1:0] pc,
                                             output logic [WORD_W-1:0] pred);
        fetchBundleT r;
        logic [7:0]  b0;
        logic [7:0]  b1;
        int          len;
        b0 = shadowByte(pc);
        b1 = shadowByte(pc + 64'd1);
        r = '{icode: b0[7:4], ifun: b0[3:0], rA: REG_NONE, rB: REG_NONE,
              valC: '0, valP: '0, stat: STAT_AOK};
        len = 1;
        case (r.icode)
            ICODE_HALT:
                r.stat = STAT_HLT;
            ICODE_NOP, ICODE_RET:
                len = 1;
            ICODE_RRMOVQ, ICODE_OPQ, ICODE_PUSHQ, ICODE_POPQ:
            begin
                {r.rA, r.rB} = b1;
                len = 2;
            end
            ICODE_IRMOVQ, ICODE_RMMOVQ, ICODE_MRMOVQ:
            begin
                {r.rA, r.rB} = b1;
                // constant stored most significant byte first
                for (int k = 2; k < 10; k++)
                    r.valC = {r.valC[55:0], shadowByte(pc + 64'(k))};
                len = 10;
            end
            ICODE_JXX, ICODE_CALL:
            begin
                for (int k = 1; k < 9; k++)
                    r.valC = {r.valC[55:0], shadowByte(pc + 64'(k))};
                len = 9;
            end
            default:
                r.stat = STAT_INS;
        endcase
        r.valP = pc + 64'(len);
        pred = (r.icode == ICODE_JXX || r.icode == ICODE_CALL) ? r.valC : r.valP;
        if (pc >= WORD_W'(IMEM_BYTES))
        begin
            r = '{icode: ICODE_NOP, ifun: 4'h0, rA: REG_NONE, rB: REG_NONE,
                  valC: '0, valP: pc, stat: STAT_ADR};
            pred = pc;
        end
        return r;
    endfunction

    // expected register value from the inputs seen at the edge
    always @(posedge clk)
    begin : predictAtEdge
        fetchBundleT       fetchExp;
        logic [WORD_W-1:0] predExp;
        fetchExp = refFetch(refPc(predPc, memFb, wbFb), predExp);
        if (memReady && fPredPc !== predExp)
        begin
            errors++;
            $display("[FAIL] %s fPredPc: expected %h, actual %h", testName, predExp, fPredPc);
        end
        if (!rstN)
            expD = BUBBLE_EXP;
        else if (!stall)
            expD = bubble ? BUBBLE_EXP : fetchExp;
        expName = testName;
        if (imemWrEn && imemWrAddr < WORD_W'(IMEM_BYTES))
            shadow[imemWrAddr[ADDR_W-1:0]] = imemWrData;
        armed = 1'b1;
    end

    // register output settled by the falling edge
    always @(negedge clk)
    begin
        if (armed)
        begin
            checks++;
            if (dOut !== expD)
            begin
                errors++;
                $display("[FAIL] %s: expected %h, actual %h", expName, expD, dOut);
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic drive(input logic [WORD_W-1:0] pc, input memFeedbackT m,
                         input wbFeedbackT w, input logic st, input logic bu, input string name);
        @(negedge clk);
        imemWrEn = 1'b0;
        predPc   = pc;
        memFb    = m;
        wbFb     = w;
        stall    = st;
        bubble   = bu;
        testName = name;
    endtask

    task automatic loadByte(input logic [WORD_W-1:0] addr, input logic [7:0] data);
        @(negedge clk);
        imemWrEn   = 1'b1;
        imemWrAddr = addr;
        imemWrData = data;
    endtask

    // first byte of the instruction in the top of the word
    task automatic emit(input logic [79:0] bytesMsb, input int len);
        for (int k = 0; k < len; k++)
            loadByte(progAddr + 64'(k), bytesMsb[79-8*k -: 8]);
        progAddr = progAddr + 64'(len);
    endtask

    task automatic checkBundle(input string name, input fetchBundleT exp);
        checks++;
        if (dOut !== exp)
        begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, dOut);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        rstN = 1'b0;
        {predPc, stall, bubble} = {64'h0, 1'b0, 1'b1};
        {memFb, wbFb} = {NO_MEM, NO_WB};
        {imemWrEn, imemWrAddr, imemWrData} = '0;
        {seed, errors, checks, armed, memReady} = {32'd77, 32'd0, 32'd0, 1'b0, 1'b0};
        testName = "reset";
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        checkBundle("reset", BUBBLE_EXP);

        // random contents everywhere while bubbles keep dOut defined
        for (int a = 0; a < IMEM_BYTES; a++)
            loadByte(64'(a), 8'($random(seed)));
        drive(64'h0, NO_MEM, NO_WB, 1'b0, 1'b1, "fill");
        memReady = 1'b1;

        // program with every form where call and jump send fetch to 0x40 and 0x50
        progAddr = 64'h0;
        emit({8'h30, 8'hF0, 64'h0123_4567_89AB_CDEF}, 10);
        emit({8'h20, 8'h03, 64'h0}, 2);
        emit({8'h40, 8'h03, 64'h10}, 10);
        emit({8'h50, 8'h13, 64'h8}, 10);
        emit({8'h61, 8'h01, 64'h0}, 2);
        emit({8'hA0, 8'h0F, 64'h0}, 2);
        emit({8'hB0, 8'h3F, 64'h0}, 2);
        emit({8'h80, 64'h40, 8'h00}, 9);
        progAddr = 64'h40;
        emit({8'h10, 72'h0}, 1);
        emit({8'h73, 64'h50, 8'h00}, 9);
        progAddr = 64'h50;
        emit({8'h90, 72'h0}, 1);
        emit({8'h00, 72'h0}, 1);

        drive(64'h0, NO_MEM, NO_WB, 1'b0, 1'b0, "in-order");
        repeat (PROG_STEPS - 1)
        begin
            @(negedge clk);
            // stands in for the F register
            predPc = fPredPc;
        end
        @(negedge clk);
        checkBundle("in-order halt", '{icode: ICODE_HALT, ifun: 4'h0, rA: REG_NONE,
                                        rB: REG_NONE, valC: '0, valP: 64'h52, stat: STAT_HLT});

        drive(64'h0A, JUMP_MISS, NO_WB, 1'b0, 1'b0, "jump miss");
        drive(64'h0A, NO_MEM, RET_WB, 1'b0, 1'b0, "ret");
        drive(64'h0A, JUMP_MISS, RET_WB, 1'b0, 1'b0, "jump over ret");
        drive(64'h0A, JUMP_TAKEN, RET_WB, 1'b0, 1'b0, "taken jump with ret");

        // pushq loads and then three stalls follow with a moving pc
        drive(64'h22, NO_MEM, NO_WB, 1'b0, 1'b0, "stall load");
        drive(64'h24, NO_MEM, NO_WB, 1'b1, 1'b0, "stall");
        held = dOut;
        drive(64'h26, NO_MEM, NO_WB, 1'b1, 1'b0, "stall");
        drive(64'h0C, JUMP_MISS, NO_WB, 1'b1, 1'b0, "stall");
        drive(64'h0C, NO_MEM, NO_WB, 1'b0, 1'b1, "bubble");
        checkBundle("stall hold", held);
        drive(64'h0C, NO_MEM, NO_WB, 1'b0, 1'b0, "after bubble");
        checkBundle("bubble", BUBBLE_EXP);

        drive(64'd1024, NO_MEM, NO_WB, 1'b0, 1'b0, "adr at end");
        drive(64'hFFFF_FFFF_FFFF_FFF3, NO_MEM, NO_WB, 1'b0, 1'b0, "adr far");
        checkBundle("adr", '{icode: ICODE_NOP, ifun: 4'h0, rA: REG_NONE, rB: REG_NONE,
                             valC: '0, valP: 64'd1024, stat: STAT_ADR});
        progAddr = 64'h70;
        emit({32'hC0D5_E0FF, 48'h0}, 4);
        // jump and irmovq whose last bytes fall past the top
        progAddr = 64'd1016;
        emit({64'h7011_2233_30F1_AABB, 16'h0}, 8);
        for (int a = 'h70; a < 'h74; a++)
            drive(64'(a), NO_MEM, NO_WB, 1'b0, 1'b0, "ins");
        drive(64'd1016, NO_MEM, NO_WB, 1'b0, 1'b0, "jump at top");
        drive(64'd1020, NO_MEM, NO_WB, 1'b0, 1'b0, "irmovq at top");
        drive(64'd1023, NO_MEM, NO_WB, 1'b0, 1'b0, "last byte");

        // low nibble walks every bank offset
        for (int i = 0; i < RAND_FETCHES; i++)
        begin
            randWord = $random(seed);
            drive({54'h0, randWord[5:0], 4'(i)}, NO_MEM, NO_WB, 1'b0, 1'b0, "random");
        end
        drive(64'h0, NO_MEM, NO_WB, 1'b0, 1'b1, "drain");
        @(negedge clk);
        #1;

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* fetchStage.sv */
// Y86-64 fetch top; NUM_BANKS a power of two >= 10, IMEM_BYTES a multiple, F register is external
`timescale 1ns/1ps

module fetchStage #(
    parameter int IMEM_BYTES = 1024,
    parameter int NUM_BANKS  = 16
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [fetchPkg::WORD_W-1:0] predPc,
    input  fetchPkg::memFeedbackT       memFb,
    input  fetchPkg::wbFeedbackT        wbFb,
    input  logic                        stall,
    input  logic                        bubble,
    input  logic                        imemWrEn,
    input  logic [fetchPkg::WORD_W-1:0] imemWrAddr,
    input  logic [7:0]                  imemWrData,
    output logic [fetchPkg::WORD_W-1:0] fPredPc,
    output fetchPkg::fetchBundleT       dOut
);
    import fetchPkg::*;

    logic [WORD_W-1:0]          pc;
    logic [NUM_BANKS-1:0][7:0]  bankBytes;
    fetchBundleT                fetched;

    // a whole instruction must fit across the lanes in one read
    if (NUM_BANKS < MAX_INSTR_BYTES || (NUM_BANKS & (NUM_BANKS - 1)) != 0)
    begin : gBadBanks
        $error("fetchStage: NUM_BANKS must be a power of two of at least 10");
    end

    fetchPcSelect uPcSelect (
        .predPc (predPc),
        .memFb  (memFb),
        .wbFb   (wbFb),
        .pc     (pc)
    );

    // one lane per byte offset, all read in the same cycle
    for (genvar i = 0; i < NUM_BANKS; i++)
    begin : gBank
        imemBank #(
            .BANK_INDEX (i),
            .IMEM_BYTES (IMEM_BYTES),
            .NUM_BANKS  (NUM_BANKS)
        ) uBank (
            .clk        (clk),
            .imemWrEn   (imemWrEn),
            .imemWrAddr (imemWrAddr),
            .imemWrData (imemWrData),
            .pc         (pc),
            .rdByte     (bankBytes[i])
        );
    end

    fetchDecode #(
        .IMEM_BYTES (IMEM_BYTES),
        .NUM_BANKS  (NUM_BANKS)
    ) uDecode (
        .pc        (pc),
        .bankBytes (bankBytes),
        .fetched   (fetched),
        .fPredPc   (fPredPc)
    );

    decodeReg uDecodeReg (
        .clk     (clk),
        .rstN    (rstN),
        .stall   (stall),
        .bubble  (bubble),
        .fetched (fetched),
        .dOut    (dOut)
    );

endmodule

/* decodeReg.sv */
// D pipeline register; stall wins over bubble, reset and bubble both load a zeroed AOK nop
`timescale 1ns/1ps

module decodeReg (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stall,
    input  logic                  bubble,
    input  fetchPkg::fetchBundleT fetched,
    output fetchPkg::fetchBundleT dOut
);
    import fetchPkg::*;

    // injected nop, registers zero rather than REG_NONE
    localparam fetchBundleT BUBBLE_NOP = '{
        icode: ICODE_NOP,
        ifun:  4'h0,
        rA:    4'h0,
        rB:    4'h0,
        valC:  '0,
        valP:  '0,
        stat:  STAT_AOK
    };

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            dOut <= BUBBLE_NOP;
        end
        else if (!stall)
        begin
            // stall keeps the old value
            if (bubble)
            begin
                dOut <= BUBBLE_NOP;
            end
            else
            begin
                dOut <= fetched;
            end
        end
    end

    // hazard control never asks for both at once
    assert property (@(posedge clk) disable iff (!rstN) !(stall && bubble))
    else
        $error("decodeReg: stall and bubble high together");

endmodule

/* fetchDecode.sv */
// fetch decode; constants big-endian, icode 12..15 is INS, pc at or past IMEM_BYTES is ADR
`timescale 1ns/1ps

module fetchDecode #(
    parameter int IMEM_BYTES = 1024,
    parameter int NUM_BANKS  = 16
) (
    input  logic [fetchPkg::WORD_W-1:0]   pc,
    input  logic [NUM_BANKS-1:0][7:0]     bankBytes,
    output fetchPkg::fetchBundleT         fetched,
    output logic [fetchPkg::WORD_W-1:0]   fPredPc
);
    import fetchPkg::*;

    localparam int OFS_W = $clog2(NUM_BANKS);

    // raw[0] is the byte at pc
    logic [0:MAX_INSTR_BYTES-1][7:0] raw;
    logic [OFS_W-1:0]                pcOfs;
    instrWordU                       instr;
    logic [3:0]                      len;
    logic                            isBranch;

    assign pcOfs = pc[OFS_W-1:0];

    // undo the interleave, byte k comes from lane (pc + k) mod NUM_BANKS
    always_comb
    begin : rotate
        logic [OFS_W-1:0] lane;
        for (int k = 0; k < MAX_INSTR_BYTES; k++)
        begin
            lane = pcOfs + OFS_W'(k);
            raw[k] = bankBytes[lane];
        end
    end

    assign instr = instrWordU'(raw);

    // jumps and calls predict their destination
    assign isBranch = (instr.regForm.icode == ICODE_JXX)
                      || (instr.regForm.icode == ICODE_CALL);

    always_comb
    begin
        // specifier byte has the same place in both forms
        fetched.icode = instr.regForm.icode;
        fetched.ifun  = instr.regForm.ifun;
        fetched.rA    = REG_NONE;
        fetched.rB    = REG_NONE;
        fetched.valC  = '0;
        fetched.stat  = STAT_AOK;
        len           = 4'd1;

        case (instr.regForm.icode)
            ICODE_HALT:
            begin
                fetched.stat = STAT_HLT;
            end
            // one byte, nothing to read
            ICODE_NOP, ICODE_RET:
            begin
                len = 4'd1;
            end
            // register byte only
            ICODE_RRMOVQ, ICODE_OPQ, ICODE_PUSHQ, ICODE_POPQ:
            begin
                fetched.rA = instr.regForm.rA;
                fetched.rB = instr.regForm.rB;
                len        = 4'd2;
            end
            // register byte plus immediate or displacement
            ICODE_IRMOVQ, ICODE_RMMOVQ, ICODE_MRMOVQ:
            begin
                fetched.rA   = instr.regForm.rA;
                fetched.rB   = instr.regForm.rB;
                fetched.valC = instr.regForm.valC;
                len          = 4'd10;
            end
            // destination right after the specifier
            ICODE_JXX, ICODE_CALL:
            begin
                fetched.valC = instr.destForm.dest;
                len          = 4'd9;
            end
            default:
            begin
                // codes 12..15, skip one byte
                fetched.stat = STAT_INS;
            end
        endcase

        fetched.valP = pc + WORD_W'(len);
        fPredPc      = isBranch ? fetched.valC : fetched.valP;

        // out of memory, fetch stands still as a nop
        if (pc >= WORD_W'(IMEM_BYTES))
        begin
            fetched.icode = ICODE_NOP;
            fetched.ifun  = 4'h0;
            fetched.rA    = REG_NONE;
            fetched.rB    = REG_NONE;
            fetched.valC  = '0;
            fetched.valP  = pc;
            fetched.stat  = STAT_ADR;
            fPredPc       = pc;
        end
    end

    // valP never runs more than one instruction ahead of pc
    always_comb
    begin : lenCheck
        assert final ((fetched.valP - pc) <= WORD_W'(MAX_INSTR_BYTES))
        else
            $error("fetchDecode: valP %0h too far from pc %0h", fetched.valP, pc);
    end

endmodule

/* imemBank.sv */
// one byte lane of the interleaved instruction memory; sizes powers of two, contents random until written
`timescale 1ns/1ps

module imemBank #(
    parameter int BANK_INDEX = 0,
    parameter int IMEM_BYTES = 1024,
    parameter int NUM_BANKS  = 16
) (
    input  logic                        clk,
    input  logic                        imemWrEn,
    input  logic [fetchPkg::WORD_W-1:0] imemWrAddr,
    input  logic [7:0]                  imemWrData,
    input  logic [fetchPkg::WORD_W-1:0] pc,
    output logic [7:0]                  rdByte
);
    import fetchPkg::*;

    localparam int ROWS  = IMEM_BYTES / NUM_BANKS;
    localparam int OFS_W = $clog2(NUM_BANKS);
    localparam int ROW_W = $clog2(ROWS);

    // byte at address a lives in bank a % NUM_BANKS, row a / NUM_BANKS
    logic [7:0]        mem [ROWS];
    logic              wrHit;
    logic [ROW_W-1:0]  wrRow;
    logic [OFS_W-1:0]  pcOfs;
    logic [WORD_W-1:0] rdRow;

    // write side
    assign wrHit = imemWrEn
                   && (imemWrAddr[OFS_W-1:0] == OFS_W'(BANK_INDEX))
                   && (imemWrAddr < WORD_W'(IMEM_BYTES));
    assign wrRow = imemWrAddr[OFS_W +: ROW_W];

    always_ff @(posedge clk)
    begin
        if (wrHit)
        begin
            mem[wrRow] <= imemWrData;
        end
    end

    // read side
    // lanes below the pc offset hold bytes of the next row
    assign pcOfs = pc[OFS_W-1:0];
    assign rdRow = (pc >> OFS_W) + WORD_W'(OFS_W'(BANK_INDEX) < pcOfs);

    // past the last row reads as zero
    assign rdByte = (rdRow < WORD_W'(ROWS)) ? mem[rdRow[ROW_W-1:0]] : 8'h00;

    // loader must stay inside memory, only the addressed lane reports
    assert property (@(posedge clk)
        (imemWrEn && (imemWrAddr[OFS_W-1:0] == OFS_W'(BANK_INDEX)))
        |-> (imemWrAddr < WORD_W'(IMEM_BYTES)))
    else
        $error("imemBank %0d: write address %0h beyond memory", BANK_INDEX, imemWrAddr);

endmodule

/* fetchPcSelect.sv */
// fetch PC mux; a not-taken jump in memory beats a ret in write-back, no other redirect exists
`timescale 1ns/1ps

module fetchPcSelect (
    input  logic [fetchPkg::WORD_W-1:0] predPc,
    input  fetchPkg::memFeedbackT       memFb,
    input  fetchPkg::wbFeedbackT        wbFb,
    output logic [fetchPkg::WORD_W-1:0] pc
);
    import fetchPkg::*;

    logic jumpMiss;
    logic retSeen;

    // jumps are predicted taken
    // so cnd low in memory means the prediction was wrong
    assign jumpMiss = (memFb.icode == ICODE_JXX) && !memFb.cnd;

    // ret target only known once write-back has the popped value
    assign retSeen = (wbFb.icode == ICODE_RET);

    always_comb
    begin
        if (jumpMiss)
        begin
            // fall-through address travels down the pipe in valA
            pc = memFb.valA;
        end
        else if (retSeen)
        begin
            // return address read from the stack
            pc = wbFb.valM;
        end
        else
        begin
            // normal case, prediction from the F register
            pc = predPc;
        end
    end

endmodule

/* fetchPkg.sv */
// Y86-64 fetch definitions; instruction constants are stored most significant byte first
package fetchPkg;

    // machine word width
    localparam int WORD_W = 64;
    // longest instruction (irmovq, rmmovq, mrmovq)
    localparam int MAX_INSTR_BYTES = 10;
    // register id for "no register"
    localparam logic [3:0] REG_NONE = 4'hF;

    // instruction codes, upper nibble of the specifier byte
    localparam logic [3:0] ICODE_HALT   = 4'd0;
    localparam logic [3:0] ICODE_NOP    = 4'd1;
    // rrmovq shares its code with cmovXX
    localparam logic [3:0] ICODE_RRMOVQ = 4'd2;
    localparam logic [3:0] ICODE_IRMOVQ = 4'd3;
    localparam logic [3:0] ICODE_RMMOVQ = 4'd4;
    localparam logic [3:0] ICODE_MRMOVQ = 4'd5;
    localparam logic [3:0] ICODE_OPQ    = 4'd6;
    localparam logic [3:0] ICODE_JXX    = 4'd7;
    localparam logic [3:0] ICODE_CALL   = 4'd8;
    localparam logic [3:0] ICODE_RET    = 4'd9;
    localparam logic [3:0] ICODE_PUSHQ  = 4'd10;
    localparam logic [3:0] ICODE_POPQ   = 4'd11;

    // status codes
    localparam logic [1:0] STAT_AOK = 2'd0;
    localparam logic [1:0] STAT_HLT = 2'd1;
    localparam logic [1:0] STAT_ADR = 2'd2;
    localparam logic [1:0] STAT_INS = 2'd3;

    // one fetched instruction, 146 bits
    typedef struct packed {
        logic [3:0]        icode;
        logic [3:0]        ifun;
        logic [3:0]        rA;
        logic [3:0]        rB;
        logic [WORD_W-1:0] valC;
        logic [WORD_W-1:0] valP;
        logic [1:0]        stat;
    } fetchBundleT;

    // memory stage feedback, valA carries the jump fall-through
    typedef struct packed {
        logic [3:0]        icode;
        logic              cnd;
        logic [WORD_W-1:0] valA;
    } memFeedbackT;

    // write-back feedback, valM carries the popped return address
    typedef struct packed {
        logic [3:0]        icode;
        logic [WORD_W-1:0] valM;
    } wbFeedbackT;

    // specifier, register byte, 8-byte constant
    typedef struct packed {
        logic [3:0]        icode;
        logic [3:0]        ifun;
        logic [3:0]        rA;
        logic [3:0]        rB;
        logic [WORD_W-1:0] valC;
    } regFormT;

    // specifier, 8-byte destination, one byte not part of the instruction
    typedef struct packed {
        logic [3:0]        icode;
        logic [3:0]        ifun;
        logic [WORD_W-1:0] dest;
        logic [7:0]        pad;
    } destFormT;

    // first instruction byte sits in the top 8 bits
    typedef union packed {
        regFormT  regForm;
        destFormT destForm;
    } instrWordU;

endpackage
